// File: include/gen_bus_macros.svh
// Console bus fabric constants
// Widths, control register pages, bank register page and reset values
// shared by the main bus and the sound-side bus blocks

`ifndef GEN_BUS_MACROS_SVH
`define GEN_BUS_MACROS_SVH

// Z80 RAM is 8 KB
`define GEN_ZRAM_AW 13

// Value returned on unmapped reads until the 68000 reads something
`define GEN_NO_DATA_INIT 16'h4E71

// Control register pages, decoded from address bits 11 to 8
`define GEN_CTRL_BUSREQ_PAGE 4'h1
`define GEN_CTRL_RESET_PAGE 4'h2

// Z80 bank register page, ZBUS address bits 14 to 8
`define GEN_BANK_PAGE 7'h60

// Idle ZBUS read byte
`define GEN_FF_BYTE 8'hFF

`endif

// File: hw/gen_bus_pkg.sv
// Console bus fabric types
// Bus vector types, master and device codes and the state machine
// encodings of the main bus and the sound-side bus

package gen_bus_pkg;

	// Main bus word address, bits 23 down to 1
	typedef logic [23:1] mbus_addr_t;
	typedef logic [15:0] bus_word_t;
	typedef logic [7:0]  bus_byte_t;
	typedef logic [15:0] z80_addr_t;
	typedef logic [14:0] zbus_addr_t;
	// Bank register holds address bits 23 to 15
	typedef logic [8:0]  bank_t;

	typedef enum logic [1:0] {
		SRC_NONE, SRC_M68K, SRC_Z80, SRC_VDP
	} mbus_src_t;

	typedef enum logic [2:0] {
		DEV_NONE, DEV_ROM, DEV_ZBUS, DEV_IO, DEV_CTRL, DEV_FDC, DEV_VDP, DEV_RAM
	} mbus_dev_t;

	typedef enum logic [3:0] {
		IDLE,
		SELECT,
		RAM_WAIT,
		RAM_READ,
		RAM_WRITE,
		EXT_READ,
		VDP_READ,
		IO_READ,
		ZBUS_READ,
		NOT_USED,
		FINISH
	} mbus_state_t;

	typedef enum logic [1:0] {
		Z_IDLE, Z_READ, Z_FINISH
	} zbus_state_t;

endpackage

// File: hw/zram.sv
// Z80 work RAM
// 8 KB byte-wide single port RAM with a registered read

`timescale 1ns/1ps
`include "gen_bus_macros.svh"

module zram (
	input  logic                      MCLK,
	input  logic [`GEN_ZRAM_AW-1:0]   addr,
	input  gen_bus_pkg::bus_byte_t    wdata,
	input  logic                      we,
	output gen_bus_pkg::bus_byte_t    rdata
);
	import gen_bus_pkg::*;

	bus_byte_t mem [0:(1 << `GEN_ZRAM_AW) - 1];

	// Read returns the old byte on a write cycle
	always_ff @(posedge MCLK) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

// File: hw/mbus_decode.sv
// Main bus address decoder
// Maps the registered bus address to a device code and drives the
// cartridge chip enables, whose halves swap with cart_n

`timescale 1ns/1ps

module mbus_decode (
	input  gen_bus_pkg::mbus_addr_t addr,
	input  logic                    cart_n,
	output gen_bus_pkg::mbus_dev_t  dev,
	output logic                    ce0_n,
	output logic                    rom_n,
	output logic                    ras2_n,
	output logic                    fdc_n
);
	import gen_bus_pkg::*;

	logic cart_space;
	logic fdc_hit;

	assign cart_space = ~addr[23];
	assign fdc_hit    = (addr[23:8] == 16'hA120);

	always_comb begin
		dev = DEV_NONE;
		if (cart_space)
			dev = DEV_ROM;
		else if (addr[23:16] == 8'hA0)
			dev = DEV_ZBUS;
		// I/O block mirrors every 32 bytes up to A10FFF
		else if (addr[23:12] == 12'hA10)
			dev = DEV_IO;
		else if (addr[23:12] == 12'hA11 && addr[7:1] == 7'd0)
			dev = DEV_CTRL;
		else if (fdc_hit)
			dev = DEV_FDC;
		else if (addr[23:21] == 3'b110 && addr[18:16] == 3'd0 && addr[7:5] == 3'd0)
			dev = DEV_VDP;
		else if (&addr[23:21])
			dev = DEV_RAM;
	end

	// Cartridge halves; cart_n high moves ce0_n to the upper 4 MB
	assign ce0_n  = ~(cart_space && addr[22] == cart_n);
	assign rom_n  = ~(cart_space && addr[22] != cart_n && !addr[21]);
	assign ras2_n = ~(cart_space && addr[22] != cart_n && addr[21]);
	assign fdc_n  = ~fdc_hit;

endmodule

// File: hw/mbus_arbiter.sv
// Main bus arbiter
// Picks one of the 68000, Z80 and video DMA masters, registers its
// address, data and strobes, walks the target device handshake and
// returns the acknowledge to the owning master

`timescale 1ns/1ps

module mbus_arbiter (
	input  logic                    MCLK,
	input  logic                    reset,
	input  logic                    m68k_as_n,
	input  logic                    m68k_uds_n,
	input  logic                    m68k_lds_n,
	input  logic                    m68k_rnw,
	input  gen_bus_pkg::mbus_addr_t m68k_addr,
	input  gen_bus_pkg::bus_word_t  m68k_wdata,
	input  logic                    z80_mreq_n,
	input  logic                    z80_rd_n,
	input  logic                    z80_wr_n,
	input  gen_bus_pkg::z80_addr_t  z80_addr,
	input  gen_bus_pkg::bus_byte_t  z80_wdata,
	input  logic                    vbus_sel,
	input  gen_bus_pkg::mbus_addr_t vbus_addr,
	input  logic                    z80_zbus_hit,
	input  gen_bus_pkg::bank_t      bank,
	input  logic                    dtack_n,
	input  logic                    ram_rdy,
	input  logic                    vdp_dtack_n,
	input  logic                    io_dtack_n,
	input  logic                    zbus_dtack_n,
	input  gen_bus_pkg::mbus_dev_t  dev,
	output gen_bus_pkg::mbus_addr_t mbus_addr,
	output gen_bus_pkg::bus_word_t  mbus_wdata,
	output logic                    mbus_rnw,
	output logic                    mbus_uds_n,
	output logic                    mbus_lds_n,
	output logic                    rom_sel,
	output logic                    ram_sel,
	output logic                    vdp_sel,
	output logic                    io_sel,
	output logic                    ctrl_sel,
	output logic                    zbus_sel,
	output logic                    fdc_sel,
	output logic                    m68k_dtack_n,
	output logic                    z80_mbus_dtack_n,
	output logic                    vbus_dtack_n,
	output logic                    m68k_owner,
	output logic                    finish_strobe
);
	import gen_bus_pkg::*;

	mbus_src_t   msrc;
	mbus_state_t state;
	logic        m68k_req;
	logic        z80_io;
	logic        ack_now;
	logic        release_bus;

	assign m68k_req = ~m68k_as_n & (~m68k_uds_n | ~m68k_lds_n);
	assign z80_io   = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n);

	// Device handshake done in the current wait state
	always_comb begin
		case (state)
			RAM_READ, RAM_WRITE: ack_now = ram_rdy;
			EXT_READ:            ack_now = ~dtack_n;
			VDP_READ:            ack_now = ~vdp_dtack_n;
			IO_READ:             ack_now = ~io_dtack_n;
			ZBUS_READ:           ack_now = ~zbus_dtack_n;
			NOT_USED:            ack_now = 1'b1;
			default:             ack_now = 1'b0;
		endcase
	end

	// Owner has dropped its request
	always_comb begin
		case (msrc)
			SRC_M68K: release_bus = m68k_as_n;
			SRC_Z80:  release_bus = ~z80_io;
			SRC_VDP:  release_bus = ~vbus_sel;
			default:  release_bus = 1'b1;
		endcase
	end

	assign m68k_owner    = (msrc == SRC_M68K);
	assign finish_strobe = (state == FINISH) && release_bus;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state            <= IDLE;
			msrc             <= SRC_NONE;
			mbus_rnw         <= 1'b1;
			mbus_uds_n       <= 1'b1;
			mbus_lds_n       <= 1'b1;
			{rom_sel, ram_sel, vdp_sel, io_sel} <= 4'b0000;
			{ctrl_sel, zbus_sel, fdc_sel}       <= 3'b000;
			m68k_dtack_n     <= 1'b1;
			z80_mbus_dtack_n <= 1'b1;
			vbus_dtack_n     <= 1'b1;
		end else begin
			case (state)
				IDLE: begin
					msrc <= SRC_NONE;
					if (m68k_req) begin
						msrc       <= SRC_M68K;
						mbus_addr  <= m68k_addr;
						mbus_wdata <= m68k_wdata;
						mbus_rnw   <= m68k_rnw;
						mbus_uds_n <= m68k_uds_n;
						mbus_lds_n <= m68k_lds_n;
						state      <= SELECT;
					end else if (z80_io && !z80_zbus_hit) begin
						// Upper half goes through the bank, 7Fxx lands on the video chip
						msrc       <= SRC_Z80;
						mbus_addr  <= z80_addr[15] ? {bank, z80_addr[14:1]}
						                           : {16'hC000, z80_addr[7:1]};
						mbus_wdata <= {z80_wdata, z80_wdata};
						mbus_rnw   <= z80_wr_n;
						mbus_uds_n <= z80_addr[0];
						mbus_lds_n <= ~z80_addr[0];
						state      <= SELECT;
					end else if (vbus_sel) begin
						msrc       <= SRC_VDP;
						mbus_addr  <= vbus_addr;
						mbus_wdata <= '0;
						mbus_rnw   <= 1'b1;
						mbus_uds_n <= 1'b0;
						mbus_lds_n <= 1'b0;
						state      <= SELECT;
					end
				end
				SELECT: begin
					case (dev)
						DEV_ROM: begin
							rom_sel <= 1'b1;
							state   <= EXT_READ;
						end
						DEV_FDC: begin
							fdc_sel <= 1'b1;
							state   <= EXT_READ;
						end
						DEV_ZBUS: begin
							zbus_sel <= 1'b1;
							state    <= ZBUS_READ;
						end
						DEV_IO: begin
							io_sel <= 1'b1;
							state  <= IO_READ;
						end
						DEV_VDP: begin
							vdp_sel <= 1'b1;
							state   <= VDP_READ;
						end
						DEV_RAM: begin
							ram_sel <= 1'b1;
							state   <= RAM_WAIT;
						end
						DEV_CTRL: begin
							ctrl_sel <= 1'b1;
							state    <= NOT_USED;
						end
						default: state <= NOT_USED;
					endcase
				end
				// RAM takes the access by pulling ram_rdy low
				RAM_WAIT: begin
					if (!ram_rdy)
						state <= mbus_rnw ? RAM_READ : RAM_WRITE;
				end
				FINISH: begin
					if (release_bus) begin
						m68k_dtack_n     <= 1'b1;
						z80_mbus_dtack_n <= 1'b1;
						vbus_dtack_n     <= 1'b1;
						mbus_rnw         <= 1'b1;
						mbus_uds_n       <= 1'b1;
						mbus_lds_n       <= 1'b1;
						{rom_sel, ram_sel, vdp_sel, io_sel} <= 4'b0000;
						{ctrl_sel, zbus_sel, fdc_sel}       <= 3'b000;
						state            <= IDLE;
					end
				end
				default: begin
					if (ack_now) begin
						m68k_dtack_n     <= (msrc != SRC_M68K);
						z80_mbus_dtack_n <= (msrc != SRC_Z80);
						vbus_dtack_n     <= (msrc != SRC_VDP);
						state            <= FINISH;
					end
				end
			endcase
		end
	end

endmodule

// File: hw/mbus_read_mux.sv
// Main bus read data steering
// Picks the selected device's read data and keeps the open-bus word,
// the last word the 68000 read, for unmapped and control reads

`timescale 1ns/1ps
`include "gen_bus_macros.svh"

module mbus_read_mux (
	input  logic                    MCLK,
	input  logic                    reset,
	input  logic                    rom_sel,
	input  logic                    ram_sel,
	input  logic                    vdp_sel,
	input  logic                    io_sel,
	input  logic                    ctrl_sel,
	input  logic                    zbus_sel,
	input  logic                    fdc_sel,
	input  gen_bus_pkg::mbus_addr_t mbus_addr,
	input  gen_bus_pkg::bus_word_t  vdi,
	input  gen_bus_pkg::bus_word_t  vdp_rdata,
	input  gen_bus_pkg::bus_byte_t  io_rdata,
	input  gen_bus_pkg::bus_byte_t  zbus_rdata,
	input  logic                    ctrl_flag,
	input  logic                    m68k_owner,
	input  logic                    finish_strobe,
	output gen_bus_pkg::bus_word_t  mbus_rdata
);
	import gen_bus_pkg::*;

	bus_word_t no_data;

	always_comb begin
		if (rom_sel || ram_sel || fdc_sel)
			mbus_rdata = vdi;
		// Status register only drives its low 10 bits
		else if (vdp_sel && mbus_addr[4:2] == 3'd1)
			mbus_rdata = {no_data[15:10], vdp_rdata[9:0]};
		else if (vdp_sel)
			mbus_rdata = vdp_rdata;
		else if (zbus_sel)
			mbus_rdata = {zbus_rdata, zbus_rdata};
		else if (io_sel)
			mbus_rdata = {io_rdata, io_rdata};
		else if (ctrl_sel)
			mbus_rdata = {no_data[15:9], ctrl_flag, no_data[7:0]};
		else
			mbus_rdata = no_data;
	end

	always_ff @(posedge MCLK) begin
		if (reset)
			no_data <= `GEN_NO_DATA_INIT;
		else if (finish_strobe && m68k_owner)
			no_data <= mbus_rdata;
	end

endmodule

// File: hw/zbus_controller.sv
// Sound-side bus controller
// Shares the Z80 RAM between main bus masters and the Z80, holds the
// bus request and Z80 reset bits and the 9-bit bank shift register

`timescale 1ns/1ps
`include "gen_bus_macros.svh"

module zbus_controller (
	input  logic                    MCLK,
	input  logic                    reset,
	input  gen_bus_pkg::mbus_addr_t mbus_addr,
	input  gen_bus_pkg::bus_word_t  mbus_wdata,
	input  logic                    mbus_rnw,
	input  logic                    mbus_uds_n,
	input  logic                    zbus_sel,
	input  logic                    ctrl_sel,
	input  gen_bus_pkg::bus_word_t  mbus_rdata,
	input  logic                    z80_mbus_dtack_n,
	input  logic                    z80_mreq_n,
	input  logic                    z80_rd_n,
	input  logic                    z80_wr_n,
	input  gen_bus_pkg::z80_addr_t  z80_addr,
	input  gen_bus_pkg::bus_byte_t  z80_wdata,
	output logic                    zbus_dtack_n,
	output gen_bus_pkg::bus_byte_t  zbus_rdata,
	output logic                    z80_wait_n,
	output gen_bus_pkg::bus_byte_t  z80_rdata,
	output logic                    z80_zbus_hit,
	output gen_bus_pkg::bank_t      bank,
	output logic                    ctrl_flag
);
	import gen_bus_pkg::*;

	zbus_state_t zstate;
	zbus_addr_t  zbus_a;
	bus_byte_t   zbus_wd;
	logic        zbus_we;
	logic        from_mbus;
	bus_byte_t   zram_q;
	bus_byte_t   zbus_di;
	bus_byte_t   z80_zbus_d;
	logic        z80_zbus_dtack_n;
	logic        z80_io;
	logic        z80_zbus_sel;
	logic        zbus_free;
	logic        busrq_n;
	logic        z80_reset_n;
	logic [3:0]  ctrl_page;

	// Z80 sees its own bus below 7F00
	assign z80_zbus_hit = ~z80_addr[15] & ~&z80_addr[14:8];
	assign z80_io       = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n);
	assign z80_zbus_sel = z80_zbus_hit & z80_io;
	assign zbus_free    = ~busrq_n & z80_reset_n;

	// RAM at 0000-3FFF with a mirror, nothing else answers
	assign zbus_di = zbus_a[14] ? `GEN_FF_BYTE : zram_q;

	zram u_zram (
		.MCLK  (MCLK),
		.addr  (zbus_a[`GEN_ZRAM_AW-1:0]),
		.wdata (zbus_wd),
		.we    (zbus_we & ~zbus_a[14]),
		.rdata (zram_q)
	);

	// --------------------
	// ZBUS access FSM
	always_ff @(posedge MCLK) begin
		if (reset) begin
			zstate           <= Z_IDLE;
			zbus_we          <= 1'b0;
			zbus_dtack_n     <= 1'b1;
			z80_zbus_dtack_n <= 1'b1;
		end else begin
			zbus_we <= 1'b0;
			if (!zbus_sel)
				zbus_dtack_n <= 1'b1;
			if (!z80_zbus_sel)
				z80_zbus_dtack_n <= 1'b1;
			case (zstate)
				Z_IDLE: begin
					if (zbus_sel && zbus_dtack_n) begin
						// Upper strobe addresses the even byte
						zbus_a    <= {mbus_addr[14:1], mbus_uds_n};
						zbus_wd   <= mbus_uds_n ? mbus_wdata[7:0] : mbus_wdata[15:8];
						zbus_we   <= ~mbus_rnw & zbus_free;
						from_mbus <= 1'b1;
						zstate    <= Z_READ;
					end else if (z80_zbus_sel && z80_zbus_dtack_n) begin
						zbus_a    <= z80_addr[14:0];
						zbus_wd   <= z80_wdata;
						zbus_we   <= ~z80_wr_n;
						from_mbus <= 1'b0;
						zstate    <= Z_READ;
					end
				end
				Z_READ: zstate <= Z_FINISH;
				default: begin
					if (from_mbus) begin
						zbus_rdata   <= zbus_free ? zbus_di : `GEN_FF_BYTE;
						zbus_dtack_n <= 1'b0;
					end else begin
						z80_zbus_d       <= zbus_di;
						z80_zbus_dtack_n <= 1'b0;
					end
					zstate <= Z_IDLE;
				end
			endcase
		end
	end

	// --------------------
	// Control registers and bank
	assign ctrl_page = mbus_addr[11:8];

	always_ff @(posedge MCLK) begin
		if (reset) begin
			busrq_n     <= 1'b1;
			z80_reset_n <= 1'b0;
			bank        <= '0;
		end else begin
			if (ctrl_sel && !mbus_rnw && !mbus_uds_n) begin
				if (ctrl_page == `GEN_CTRL_BUSREQ_PAGE)
					busrq_n <= ~mbus_wdata[8];
				if (ctrl_page == `GEN_CTRL_RESET_PAGE)
					z80_reset_n <= mbus_wdata[8];
			end
			// Serial load, LSB of each write enters at the top
			if (zbus_we && zbus_a[14:8] == `GEN_BANK_PAGE)
				bank <= {zbus_wd[0], bank[8:1]};
		end
	end

	// Grant follows the request directly
	assign ctrl_flag = (ctrl_page == `GEN_CTRL_BUSREQ_PAGE) ? (busrq_n | ~z80_reset_n) :
	                   (ctrl_page == `GEN_CTRL_RESET_PAGE) ? z80_reset_n : 1'b0;

	assign z80_wait_n = ~z80_io | ~z80_zbus_dtack_n | ~z80_mbus_dtack_n;
	assign z80_rdata  = !z80_zbus_dtack_n ? z80_zbus_d :
	                    z80_addr[0] ? mbus_rdata[7:0] : mbus_rdata[15:8];

endmodule

// File: hw/gen_bus_top.sv
// Console system bus fabric
// Main bus arbiter and decoder, read data steering and the sound-side
// bus with its Z80 RAM, bank window and control registers

`timescale 1ns/1ps

module gen_bus_top (
	input  logic                    MCLK,
	input  logic                    reset,
	input  logic                    m68k_as_n,
	input  logic                    m68k_uds_n,
	input  logic                    m68k_lds_n,
	input  logic                    m68k_rnw,
	input  gen_bus_pkg::mbus_addr_t m68k_addr,
	input  gen_bus_pkg::bus_word_t  m68k_wdata,
	output logic                    m68k_dtack_n,
	output gen_bus_pkg::bus_word_t  mbus_rdata,
	input  logic                    z80_mreq_n,
	input  logic                    z80_rd_n,
	input  logic                    z80_wr_n,
	input  gen_bus_pkg::z80_addr_t  z80_addr,
	input  gen_bus_pkg::bus_byte_t  z80_wdata,
	output logic                    z80_wait_n,
	output gen_bus_pkg::bus_byte_t  z80_rdata,
	input  logic                    vbus_sel,
	input  gen_bus_pkg::mbus_addr_t vbus_addr,
	output logic                    vbus_dtack_n,
	output gen_bus_pkg::mbus_addr_t va,
	output gen_bus_pkg::bus_word_t  vdo,
	input  gen_bus_pkg::bus_word_t  vdi,
	output logic                    rnw,
	output logic                    uds_n,
	output logic                    lds_n,
	input  logic                    dtack_n,
	output logic                    ram_ce_n,
	input  logic                    ram_rdy,
	output logic                    ce0_n,
	output logic                    rom_n,
	output logic                    ras2_n,
	output logic                    fdc_n,
	input  logic                    cart_n,
	output logic                    vdp_sel,
	input  gen_bus_pkg::bus_word_t  vdp_rdata,
	input  logic                    vdp_dtack_n,
	output logic                    io_sel,
	input  gen_bus_pkg::bus_byte_t  io_rdata,
	input  logic                    io_dtack_n
);
	import gen_bus_pkg::*;

	mbus_dev_t dev;
	bank_t     bank;
	bus_byte_t zbus_rdata;
	logic      rom_sel, ram_sel, ctrl_sel, zbus_sel, fdc_sel;
	logic      zbus_dtack_n, z80_mbus_dtack_n, z80_zbus_hit;
	logic      ctrl_flag, m68k_owner, finish_strobe;

	assign ram_ce_n = ~ram_sel;

	mbus_decode u_decode (
		.addr (va), .cart_n (cart_n), .dev (dev),
		.ce0_n (ce0_n), .rom_n (rom_n), .ras2_n (ras2_n), .fdc_n (fdc_n)
	);

	mbus_arbiter u_arbiter (
		.MCLK (MCLK), .reset (reset),
		.m68k_as_n (m68k_as_n), .m68k_uds_n (m68k_uds_n), .m68k_lds_n (m68k_lds_n),
		.m68k_rnw (m68k_rnw), .m68k_addr (m68k_addr), .m68k_wdata (m68k_wdata),
		.z80_mreq_n (z80_mreq_n), .z80_rd_n (z80_rd_n), .z80_wr_n (z80_wr_n),
		.z80_addr (z80_addr), .z80_wdata (z80_wdata),
		.vbus_sel (vbus_sel), .vbus_addr (vbus_addr),
		.z80_zbus_hit (z80_zbus_hit), .bank (bank),
		.dtack_n (dtack_n), .ram_rdy (ram_rdy), .vdp_dtack_n (vdp_dtack_n),
		.io_dtack_n (io_dtack_n), .zbus_dtack_n (zbus_dtack_n), .dev (dev),
		.mbus_addr (va), .mbus_wdata (vdo), .mbus_rnw (rnw),
		.mbus_uds_n (uds_n), .mbus_lds_n (lds_n),
		.rom_sel (rom_sel), .ram_sel (ram_sel), .vdp_sel (vdp_sel), .io_sel (io_sel),
		.ctrl_sel (ctrl_sel), .zbus_sel (zbus_sel), .fdc_sel (fdc_sel),
		.m68k_dtack_n (m68k_dtack_n), .z80_mbus_dtack_n (z80_mbus_dtack_n),
		.vbus_dtack_n (vbus_dtack_n),
		.m68k_owner (m68k_owner), .finish_strobe (finish_strobe)
	);

	mbus_read_mux u_read_mux (
		.MCLK (MCLK), .reset (reset),
		.rom_sel (rom_sel), .ram_sel (ram_sel), .vdp_sel (vdp_sel), .io_sel (io_sel),
		.ctrl_sel (ctrl_sel), .zbus_sel (zbus_sel), .fdc_sel (fdc_sel),
		.mbus_addr (va), .vdi (vdi), .vdp_rdata (vdp_rdata), .io_rdata (io_rdata),
		.zbus_rdata (zbus_rdata), .ctrl_flag (ctrl_flag),
		.m68k_owner (m68k_owner), .finish_strobe (finish_strobe),
		.mbus_rdata (mbus_rdata)
	);

	zbus_controller u_zbus (
		.MCLK (MCLK), .reset (reset),
		.mbus_addr (va), .mbus_wdata (vdo), .mbus_rnw (rnw), .mbus_uds_n (uds_n),
		.zbus_sel (zbus_sel), .ctrl_sel (ctrl_sel),
		.mbus_rdata (mbus_rdata), .z80_mbus_dtack_n (z80_mbus_dtack_n),
		.z80_mreq_n (z80_mreq_n), .z80_rd_n (z80_rd_n), .z80_wr_n (z80_wr_n),
		.z80_addr (z80_addr), .z80_wdata (z80_wdata),
		.zbus_dtack_n (zbus_dtack_n), .zbus_rdata (zbus_rdata),
		.z80_wait_n (z80_wait_n), .z80_rdata (z80_rdata),
		.z80_zbus_hit (z80_zbus_hit), .bank (bank), .ctrl_flag (ctrl_flag)
	);

endmodule

// File: testbench/tb_gen_bus.sv
// Bus fabric testbench
// Runs a table of 68000, Z80 and video DMA accesses against the fabric
// with ROM and RAM responders, and checks data, enables and bank mapping

`timescale 1ns/1ps

module tb_gen_bus;
	import gen_bus_pkg::*;

	localparam int op_m_rd = 0, op_m_wr = 1, op_z_rd = 2, op_z_wr = 3;
	localparam int op_v_rd = 4, op_dual = 5;

	// Fixed read words of the video chip and I/O responders
	localparam bus_word_t vdp_word = 16'h6B1D;
	localparam bus_byte_t io_byte  = 8'hA5;

	typedef struct {
		int          kind;
		logic [23:0] addr;
		logic [23:0] addr2;
		logic [15:0] wdata;
		logic        uds;
		logic        lds;
		logic        cart;
		logic [15:0] exp;
		logic [15:0] exp2;
		logic [15:0] mask;
	} row_t;

	logic MCLK = 1'b0, reset = 1'b1;
	logic m68k_as_n = 1'b1, m68k_uds_n = 1'b1, m68k_lds_n = 1'b1, m68k_rnw = 1'b1;
	mbus_addr_t m68k_addr = '0, vbus_addr = '0;
	bus_word_t m68k_wdata = '0, vdp_rdata = vdp_word;
	logic z80_mreq_n = 1'b1, z80_rd_n = 1'b1, z80_wr_n = 1'b1, vbus_sel = 1'b0;
	z80_addr_t z80_addr = '0;
	bus_byte_t z80_wdata = '0, io_rdata = io_byte;
	logic dtack_n = 1'b1, ram_rdy = 1'b1, cart_n = 1'b0;
	logic vdp_dtack_n = 1'b1, io_dtack_n = 1'b1;
	bus_word_t vdi, vdo, mbus_rdata;
	mbus_addr_t va;
	bus_byte_t z80_rdata;
	logic m68k_dtack_n, z80_wait_n, vbus_dtack_n, rnw, uds_n, lds_n;
	logic ram_ce_n, ce0_n, rom_n, ras2_n, fdc_n, vdp_sel, io_sel;

	row_t rows[$];
	int   errors = 0;
	int   checks = 0;
	int   cycles = 0;
	int   limit = 1000;
	int   rom_cnt = 0;
	int   ram_phase = 0;

	gen_bus_top UUT (.*);

	always #50 MCLK = ~MCLK;

	// --------------------
	// Slave responders
	// ROM and RAM words equal the low 16 bits of the byte address
	assign vdi = {va[15:1], 1'b0};

	always @(negedge MCLK) begin
		if ((!ce0_n || !rom_n || !ras2_n || !fdc_n) && (!uds_n || !lds_n)) begin
			if (rom_cnt == 2)
				dtack_n <= 1'b0;
			else
				rom_cnt <= rom_cnt + 1;
		end else begin
			rom_cnt <= 0;
			dtack_n <= 1'b1;
		end
	end

	// RAM accepts with ram_rdy low, then raises it with data
	always @(negedge MCLK) begin
		if (reset || ram_ce_n) begin
			ram_rdy   <= 1'b1;
			ram_phase <= 0;
		end else if (ram_phase == 0) begin
			ram_rdy   <= 1'b0;
			ram_phase <= 1;
		end else begin
			ram_rdy   <= 1'b1;
			ram_phase <= 2;
		end
	end

	// Video chip and I/O ports answer one cycle after their select
	always @(negedge MCLK) begin
		vdp_dtack_n <= !vdp_sel;
		io_dtack_n  <= !io_sel;
	end

	always @(posedge MCLK) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("timeout: no acknowledge after %0d cycles", cycles);
			$display("checks=%0d errors=%0d", checks, errors);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// --------------------
	task automatic check_value(input string what, input logic [15:0] got,
			input logic [15:0] exp, input logic [15:0] mask);
		checks++;
		assert ((got & mask) === (exp & mask)) else begin
			errors++;
			$display("error %0t: %s got %h expected %h", $time, what, got & mask, exp & mask);
		end
	endtask

	task automatic add_row(input int kind, input logic [23:0] addr, input logic [23:0] addr2,
			input logic [15:0] wdata, input logic uds, input logic lds, input logic cart,
			input logic [15:0] exp, input logic [15:0] exp2, input logic [15:0] mask);
		row_t r;
		r = '{kind, addr, addr2, wdata, uds, lds, cart, exp, exp2, mask};
		rows.push_back(r);
	endtask

	task automatic start_m68k(input row_t r, input logic read);
		m68k_addr  = r.addr[23:1];
		m68k_wdata = r.wdata;
		m68k_rnw   = read;
		m68k_uds_n = r.uds;
		m68k_lds_n = r.lds;
		m68k_as_n  = 1'b0;
	endtask

	task automatic m68k_access(input row_t r, input logic read);
		logic lower;
		logic ce0_act;
		start_m68k(r, read);
		@(negedge MCLK);
		while (m68k_dtack_n)
			@(negedge MCLK);
		if (read)
			check_value("68000 read", mbus_rdata, r.exp, r.mask);
		else
			check_value("write data", vdo, r.wdata, 16'hFFFF);
		check_value("rnw", rnw, read, 16'h1);
		// Floppy window is A120xx
		check_value("fdc_n", fdc_n, r.addr[23:8] != 16'hA120, 16'h1);
		// Cartridge enables: cart_n high swaps the 4 MB halves
		if (!r.addr[23]) begin
			lower   = !r.addr[22];
			ce0_act = r.cart ? !lower : lower;
			check_value("ce0_n", ce0_n, !ce0_act, 16'h1);
			check_value("rom_n", rom_n, !(!ce0_act && !r.addr[21]), 16'h1);
			check_value("ras2_n", ras2_n, !(!ce0_act && r.addr[21]), 16'h1);
		end
		m68k_as_n  = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		while (!m68k_dtack_n)
			@(negedge MCLK);
	endtask

	task automatic z80_access(input row_t r, input logic read);
		z80_addr   = r.addr[15:0];
		z80_wdata  = r.wdata[7:0];
		z80_rd_n   = !read;
		z80_wr_n   = read;
		z80_mreq_n = 1'b0;
		@(negedge MCLK);
		while (!z80_wait_n)
			@(negedge MCLK);
		if (read)
			check_value("Z80 read", {8'h00, z80_rdata}, r.exp, 16'h00FF);
		// Banked reads carry the expected byte address in addr2
		if (r.addr[15]) begin
			check_value("bank address", va[23:8], r.addr2[23:8], 16'hFFFF);
			check_value("bank address low", va[7:1], r.addr2[7:1], 16'h007F);
			check_value("uds_n", uds_n, r.addr[0], 16'h1);
			check_value("lds_n", lds_n, !r.addr[0], 16'h1);
		end
		z80_mreq_n = 1'b1;
		z80_rd_n   = 1'b1;
		z80_wr_n   = 1'b1;
		@(negedge MCLK);
	endtask

	task automatic vdma_read(input row_t r);
		vbus_addr = r.addr[23:1];
		vbus_sel  = 1'b1;
		@(negedge MCLK);
		while (vbus_dtack_n)
			@(negedge MCLK);
		check_value("video DMA read", mbus_rdata, r.exp, r.mask);
		vbus_sel = 1'b0;
		while (!vbus_dtack_n)
			@(negedge MCLK);
	endtask

	// 68000 and video DMA request in the same cycle
	task automatic dual_read(input row_t r);
		logic got_m;
		logic got_v;
		got_m = 1'b0;
		got_v = 1'b0;
		start_m68k(r, 1'b1);
		vbus_addr = r.addr2[23:1];
		vbus_sel  = 1'b1;
		while (!(got_m && got_v)) begin
			@(negedge MCLK);
			if (!got_m && !m68k_dtack_n) begin
				check_value("68000 first", vbus_dtack_n, 1'b1, 16'h1);
				check_value("68000 read", mbus_rdata, r.exp, r.mask);
				m68k_as_n  = 1'b1;
				m68k_uds_n = 1'b1;
				m68k_lds_n = 1'b1;
				got_m      = 1'b1;
			end else if (!got_v && !vbus_dtack_n) begin
				check_value("video after 68000", got_m, 1'b1, 16'h1);
				check_value("video DMA read", mbus_rdata, r.exp2, r.mask);
				vbus_sel = 1'b0;
				got_v    = 1'b1;
			end
		end
		while (!vbus_dtack_n || !m68k_dtack_n)
			@(negedge MCLK);
	endtask

	// --------------------
	initial begin
		bus_byte_t r1, r2, r3;
		bank_t     bank_val;
		int        seed_val;
		seed_val = $urandom(32'hf86);
		r1 = $urandom;
		r2 = $urandom;
		r3 = $urandom;
		bank_val = 9'h00A;

		// Open bus and cartridge ROM
		add_row(op_m_rd, 24'hA13000, 0, 0, 0, 0, 0, 16'h4E71, 0, 16'hFFFF);
		add_row(op_m_rd, 24'h001234, 0, 0, 0, 0, 0, 16'h1234, 0, 16'hFFFF);
		add_row(op_m_rd, 24'hA13002, 0, 0, 0, 0, 0, 16'h1234, 0, 16'hFFFF);
		add_row(op_m_rd, 24'h452468, 0, 0, 0, 0, 0, 16'h2468, 0, 16'hFFFF);
		add_row(op_m_rd, 24'h012346, 0, 0, 0, 0, 1, 16'h2346, 0, 16'hFFFF);
		add_row(op_m_rd, 24'h6ABCDE, 0, 0, 0, 0, 1, 16'hBCDE, 0, 16'hFFFF);
		add_row(op_m_rd, 24'hA13010, 0, 0, 0, 0, 0, 16'hBCDE, 0, 16'hFFFF);
		add_row(op_m_rd, 24'h612340, 0, 0, 0, 0, 0, 16'h2340, 0, 16'hFFFF);
		// Floppy, video chip and a mirrored I/O port
		add_row(op_m_rd, 24'hA12004, 0, 0, 0, 0, 0, 16'h2004, 0, 16'hFFFF);
		add_row(op_m_rd, 24'hC00008, 0, 0, 0, 0, 0, vdp_word, 0, 16'hFFFF);
		add_row(op_m_rd, 24'hA10043, 0, 0, 1, 0, 0, {io_byte, io_byte}, 0, 16'hFFFF);
		add_row(op_m_rd, 24'hA13020, 0, 0, 0, 0, 0, {io_byte, io_byte}, 0, 16'hFFFF);
		// ZBUS gate and control registers
		add_row(op_m_rd, 24'hA00010, 0, 0, 0, 0, 0, 16'hFFFF, 0, 16'hFFFF);
		add_row(op_m_wr, 24'hA11100, 0, 16'h0100, 0, 0, 0, 0, 0, 0);
		add_row(op_m_wr, 24'hA11200, 0, 16'h0100, 0, 0, 0, 0, 0, 0);
		add_row(op_m_rd, 24'hA11100, 0, 0, 0, 0, 0, 16'h0000, 0, 16'h0100);
		add_row(op_m_rd, 24'hA11200, 0, 0, 0, 0, 0, 16'h0100, 0, 16'h0100);
		add_row(op_m_wr, 24'hA00030, 0, 16'h1111, 0, 1, 0, 0, 0, 0);
		add_row(op_m_wr, 24'hA11100, 0, 16'h0000, 0, 0, 0, 0, 0, 0);
		add_row(op_m_wr, 24'hA00030, 0, 16'h2222, 0, 1, 0, 0, 0, 0);
		add_row(op_m_wr, 24'hA11100, 0, 16'h0100, 0, 0, 0, 0, 0, 0);
		add_row(op_m_rd, 24'hA00030, 0, 0, 0, 1, 0, 16'h1111, 0, 16'hFFFF);
		add_row(op_m_wr, 24'hA00040, 0, {r1, 8'h00}, 0, 1, 0, 0, 0, 0);
		add_row(op_m_wr, 24'hA00040, 0, {8'h00, r2}, 1, 0, 0, 0, 0, 0);
		add_row(op_m_rd, 24'hA00040, 0, 0, 0, 1, 0, {r1, r1}, 0, 16'hFFFF);
		add_row(op_m_rd, 24'hA00041, 0, 0, 1, 0, 0, {r2, r2}, 0, 16'hFFFF);
		// Shared Z80 RAM, even byte is the upper lane
		add_row(op_z_rd, 24'h0040, 0, 0, 1, 1, 0, {8'h00, r1}, 0, 16'h00FF);
		add_row(op_z_rd, 24'h0041, 0, 0, 1, 1, 0, {8'h00, r2}, 0, 16'h00FF);
		add_row(op_z_wr, 24'h0050, 0, {8'h00, r3}, 1, 1, 0, 0, 0, 0);
		add_row(op_m_rd, 24'hA00050, 0, 0, 0, 1, 0, {r3, r3}, 0, 16'hFFFF);
		// Bank register, first write ends up in bit 0
		for (int i = 0; i < 9; i++)
			add_row(op_z_wr, 24'h6000, 0, {15'd0, bank_val[i]}, 1, 1, 0, 0, 0, 0);
		add_row(op_z_rd, 24'h9235, {bank_val, 15'h1235}, 0, 1, 1, 0, 16'h0034, 0, 16'h00FF);
		add_row(op_z_rd, 24'h9ABC, {bank_val, 15'h1ABC}, 0, 1, 1, 0, 16'h001A, 0, 16'h00FF);
		// Video DMA, RAM and simultaneous requests
		add_row(op_v_rd, 24'h003456, 0, 0, 0, 0, 0, 16'h3456, 0, 16'hFFFF);
		add_row(op_m_rd, 24'hE00010, 0, 0, 0, 0, 0, 16'h0010, 0, 16'hFFFF);
		add_row(op_dual, 24'h000100, 24'h000200, 0, 0, 0, 0, 16'h0100, 16'h0200, 16'hFFFF);
		limit = 5 + 60 * rows.size();

		repeat (5) @(negedge MCLK);
		reset = 1'b0;
		@(negedge MCLK);

		foreach (rows[i]) begin
			cart_n = rows[i].cart;
			case (rows[i].kind)
				op_m_rd: m68k_access(rows[i], 1'b1);
				op_m_wr: m68k_access(rows[i], 1'b0);
				op_z_rd: z80_access(rows[i], 1'b1);
				op_z_wr: z80_access(rows[i], 1'b0);
				op_v_rd: vdma_read(rows[i]);
				default: dual_read(rows[i]);
			endcase
		end

		$display("checks=%0d errors=%0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: gen_bus.f
+incdir+include
hw/gen_bus_pkg.sv
hw/zram.sv
hw/mbus_decode.sv
hw/mbus_arbiter.sv
hw/mbus_read_mux.sv
hw/zbus_controller.sv
hw/gen_bus_top.sv
testbench/tb_gen_bus.sv

// File: Bender.yml
package:
  name: gen_bus

sources:
  - include_dirs:
      - include
    files:
      - hw/gen_bus_pkg.sv
      - hw/zram.sv
      - hw/mbus_decode.sv
      - hw/mbus_arbiter.sv
      - hw/mbus_read_mux.sv
      - hw/zbus_controller.sv
      - hw/gen_bus_top.sv
  - target: test
    files:
      - testbench/tb_gen_bus.sv
